// ==== common/vmaBus.sv ====
`include "vma_params.svh"

interface vmaBus;
  import vmaPkg::*;

  // Current VMA, written by the source block
  vmaWord_u vma;

  // Context registers
  vmaWord_u pc;
  vmaWord_u held;
  vmaWord_u adrBrk;
  logic [`VMA_SECTION_WIDTH-1:0] prevSec;

  modport source (
    input  pc,
    input  prevSec,
    output vma
  );

  modport ctx (
    input  vma,
    output pc,
    output held,
    output prevSec,
    output adrBrk
  );

  modport decode (
    input vma,
    input pc,
    input held,
    input prevSec,
    input adrBrk
  );

endinterface

// ==== common/vmaPkg.sv ====
`include "vma_params.svh"

package vmaPkg;

  // Offset split as the decode logic sees it
  typedef struct packed {
    logic [1:0] hiPair;
    logic [7:0] page;
    logic [7:0] low;
  } vmaOffset_t;

  typedef struct packed {
    logic                            misc;
    logic [`VMA_SECTION_WIDTH-1:0]   section;
    vmaOffset_t                      offset;
  } vmaFields_t;

  // Flat view for counting and compares, field view for decode
  typedef union packed {
    logic [`VMA_WIDTH-1:0] flat;
    vmaFields_t            f;
  } vmaWord_u;

  // Section source on a VMA load
  typedef enum logic [1:0] {
    keepVma     = 2'd0,
    fromPc      = 2'd1,
    fromPrevSec = 2'd2,
    fromAd      = 2'd3
  } sectionSrc_e;

  typedef enum logic [2:0] {
    diagVma     = 3'd0,
    diagPc      = 3'd1,
    diagHeld    = 3'd2,
    diagAdrBrk  = 3'd3,
    diagPrevSec = 3'd4,
    diagFlags   = 3'd5,
    diagRsvd6   = 3'd6,
    diagRsvd7   = 3'd7
  } diagSel_e;

endpackage

// ==== common/vma_params.svh ====
`ifndef VMA_PARAMS_SVH
`define VMA_PARAMS_SVH

// Full virtual address, original bits 12..35
`define VMA_WIDTH 24

// Section number, original bits 13..17
`define VMA_SECTION_WIDTH 5

// In-section offset, original bits 18..35
`define VMA_OFFSET_WIDTH 18

// Microcode magic field fed to the address adder
`define VMA_MAGIC_WIDTH 5

// Diagnostic bus and data path word
`define EBUS_WIDTH 36

`endif

// ==== design/vmaTop.sv ====
`include "vma_params.svh"

module vmaTop (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [`EBUS_WIDTH-1:0]        ad,
  input  logic [`VMA_MAGIC_WIDTH-1:0]   magic,
  input  logic                          magicEn,
  input  logic                          vmaLoad,
  input  logic                          vmaCount,
  input  logic                          vmaAdSel,
  input  logic                          vmaInc,
  input  vmaPkg::sectionSrc_e           sectionSrc,
  input  logic                          sectionEn,
  input  logic                          loadPc,
  input  logic                          loadHeld,
  input  logic                          selHeld,
  input  logic                          loadPrevContext,
  input  logic                          dataoApr,
  input  logic                          vmaExtended,
  input  logic                          vmaFetch,
  input  logic                          pageUebrRef,
  input  logic                          readOrWrite,
  input  logic                          adrErr,
  input  logic                          readVma,
  input  vmaPkg::diagSel_e              diagSel,
  output logic [`VMA_WIDTH-1:0]         vma,
  output logic [`VMA_WIDTH-1:0]         pc,
  output logic [`VMA_WIDTH-1:0]         heldOrPc,
  output logic                          acRef,
  output logic                          match,
  output logic [`EBUS_WIDTH-1:0]        ebusData,
  output logic                          ebusDriving
);

  vmaBus bus ();

  vmaSource i_vmaSource (
    .clk(clk), .reset(reset), .ad(ad), .magic(magic), .magicEn(magicEn),
    .vmaAdSel(vmaAdSel), .vmaInc(vmaInc), .sectionSrc(sectionSrc),
    .sectionEn(sectionEn), .vmaLoad(vmaLoad), .vmaCount(vmaCount), .bus(bus)
  );

  vmaContext i_vmaContext (
    .clk(clk), .reset(reset), .ad(ad), .loadPc(loadPc), .loadHeld(loadHeld),
    .selHeld(selHeld), .loadPrevContext(loadPrevContext), .dataoApr(dataoApr),
    .heldOrPc(heldOrPc), .bus(bus)
  );

  vmaDecode i_vmaDecode (
    .vmaExtended(vmaExtended), .vmaFetch(vmaFetch), .pageUebrRef(pageUebrRef),
    .readOrWrite(readOrWrite), .adrErr(adrErr), .readVma(readVma),
    .diagSel(diagSel), .acRef(acRef), .match(match), .ebusData(ebusData),
    .ebusDriving(ebusDriving), .bus(bus)
  );

  assign vma = bus.vma.flat;
  assign pc  = bus.pc.flat;

endmodule

// ==== filelist.f ====
+incdir+common
+incdir+testbench
common/vmaPkg.sv
common/vmaBus.sv
vma/vmaSource.sv
vma/vmaContext.sv
vma/vmaDecode.sv
design/vmaTop.sv
testbench/vmaTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module vmaTb -o vmaSim \
  && ./obj_dir/vmaSim | grep "STATUS: PASS" \
  || { echo "simulation did not pass"; exit 1; }

// ==== testbench/vmaTbModel.svh ====
`ifndef VMA_TB_MODEL_SVH
`define VMA_TB_MODEL_SVH

// Word layout: misc 23, section 22:18, high pair 17:16, page 15:8, low byte 7:0

function automatic logic [23:0] vmaAfterLoad(
  input logic [23:0] cur,
  input logic [23:0] pcW,
  input logic [4:0]  prevSec,
  input logic [35:0] adVal,
  input logic        adSel,
  input logic        secEn,
  input sectionSrc_e src,
  input logic        magEn,
  input logic [4:0]  mag,
  input logic        inc
);
  logic [4:0]  sec;
  logic [17:0] off;
  sec = cur[22:18];
  if (secEn) begin
    case (src)
      fromPc:      sec = pcW[22:18];
      fromPrevSec: sec = prevSec;
      fromAd:      sec = adVal[22:18];
      default:     sec = cur[22:18];
    endcase
  end
  if (adSel)
    off = adVal[17:0];
  else if (magEn)
    off = pcW[17:0] + {13'd0, mag};
  else
    off = pcW[17:0] + {17'd0, inc};
  return {adVal[23], sec, off};
endfunction

function automatic logic isLocalRef(input logic [23:0] w, input logic ext, input logic fetch);
  return !ext || fetch || w[22:18] == 5'd0;
endfunction

function automatic logic miscClear(input logic [23:0] w, input logic err);
  return !w[23] && w[17:16] == 2'd0 && !err;
endfunction

function automatic logic acRefRule(input logic [23:0] w, input logic ext, input logic fetch,
                                   input logic uebr, input logic rw, input logic err);
  return w[15:8] == 8'd0 && (miscClear(w, err) || w[7:4] == 4'd0) && uebr && rw &&
         isLocalRef(w, ext, fetch);
endfunction

function automatic logic [35:0] diagWordFor(
  input diagSel_e    sel,
  input logic [23:0] vmaW,
  input logic [23:0] pcW,
  input logic [23:0] heldW,
  input logic [23:0] brkW,
  input logic [4:0]  prevSec,
  input logic        ext,
  input logic        fetch,
  input logic        uebr,
  input logic        rw,
  input logic        err
);
  logic [6:0] flags;
  flags[0] = acRefRule(vmaW, ext, fetch, uebr, rw, err);
  flags[1] = vmaW[22:18] != 5'd0 && isLocalRef(vmaW, ext, fetch) &&
             miscClear(vmaW, err) && vmaW[15:8] == 8'd0;
  flags[2] = vmaW[22:0] == brkW[22:0];
  flags[3] = miscClear(vmaW, err);
  flags[4] = vmaW[22:18] == 5'd0;
  flags[5] = pcW[22:18] == 5'd0;
  flags[6] = prevSec == 5'd0;
  case (sel)
    diagVma:     return {12'd0, vmaW};
    diagPc:      return {12'd0, pcW};
    diagHeld:    return {12'd0, heldW};
    diagAdrBrk:  return {12'd0, brkW};
    diagPrevSec: return {31'd0, prevSec};
    diagFlags:   return {29'd0, flags};
    default:     return 36'd0;
  endcase
endfunction

`endif

// ==== testbench/vmaTb.sv ====
`include "vma_params.svh"

module vmaTb;
  import vmaPkg::*;

  logic                          clk;
  logic                          reset;
  logic [`EBUS_WIDTH-1:0]        ad;
  logic [`VMA_MAGIC_WIDTH-1:0]   magic;
  logic                          magicEn;
  logic                          vmaLoad;
  logic                          vmaCount;
  logic                          vmaAdSel;
  logic                          vmaInc;
  sectionSrc_e                   sectionSrc;
  logic                          sectionEn;
  logic                          loadPc;
  logic                          loadHeld;
  logic                          selHeld;
  logic                          loadPrevContext;
  logic                          dataoApr;
  logic                          vmaExtended;
  logic                          vmaFetch;
  logic                          pageUebrRef;
  logic                          readOrWrite;
  logic                          adrErr;
  logic                          readVma;
  diagSel_e                      diagSel;
  logic [`VMA_WIDTH-1:0]         vma;
  logic [`VMA_WIDTH-1:0]         pc;
  logic [`VMA_WIDTH-1:0]         heldOrPc;
  logic                          acRef;
  logic                          match;
  logic [`EBUS_WIDTH-1:0]        ebusData;
  logic                          ebusDriving;

  logic [31:0]                   lcgState;
  // Shadow copies of the DUT registers
  logic [`VMA_WIDTH-1:0]         vmaModel;
  logic [`VMA_WIDTH-1:0]         pcModel;
  logic [`VMA_WIDTH-1:0]         heldModel;
  logic [`VMA_WIDTH-1:0]         adrBrkModel;
  logic [`VMA_SECTION_WIDTH-1:0] prevSecModel;

  `include "vmaTbModel.svh"

  vmaTop i_vmaTop (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  function automatic logic [`EBUS_WIDTH-1:0] randAd();
    logic [31:0] hi;
    hi = nextRand();
    return {hi[31:28], nextRand()};
  endfunction

  task automatic checkEq(input logic [`EBUS_WIDTH-1:0] got,
                         input logic [`EBUS_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      $display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic tick();
    @(negedge clk);
  endtask

  task automatic loadVma(input logic [`EBUS_WIDTH-1:0] adVal, input logic adSel,
                         input logic secEn, input sectionSrc_e src, input logic magEn,
                         input logic [4:0] mag, input logic inc);
    ad = adVal;
    vmaAdSel = adSel;
    sectionEn = secEn;
    sectionSrc = src;
    magicEn = magEn;
    magic = mag;
    vmaInc = inc;
    vmaLoad = 1'b1;
    vmaModel = vmaAfterLoad(vmaModel, pcModel, prevSecModel, adVal, adSel, secEn, src,
                            magEn, mag, inc);
    tick();
    vmaLoad = 1'b0;
    checkEq(vma, vmaModel, "vma after load");
  endtask

  task automatic capturePc();
    loadPc = 1'b1;
    tick();
    loadPc = 1'b0;
    pcModel = vmaModel;
    checkEq(pc, pcModel, "pc after capture");
  endtask

  task automatic loadPrevSection();
    ad = randAd();
    loadPrevContext = 1'b1;
    tick();
    loadPrevContext = 1'b0;
    prevSecModel = ad[22:18];
  endtask

  task automatic resetTest();
    int waited;
    waited = 0;
    while (vma !== '0 && waited < 20) begin
      tick();
      waited++;
    end
    if (vma !== '0) begin
      $display("timeout: the VMA register did not clear after reset");
      $display("STATUS: FAIL");
      $fatal(1, "reset timeout");
    end
    checkEq(pc, 36'd0, "pc after reset");
    checkEq(heldOrPc, 36'd0, "heldOrPc after reset");
    checkEq(ebusData, 36'd0, "ebusData after reset");
    checkEq(ebusDriving, 36'd0, "ebusDriving after reset");
  endtask

  task automatic loadTest();
    logic [31:0] r;
    loadVma(randAd(), 1'b1, 1'b1, fromAd, 1'b0, 5'd0, 1'b0);
    capturePc();
    r = nextRand();
    loadVma(randAd(), 1'b0, 1'b0, keepVma, 1'b1, r[4:0], 1'b0);
    loadVma(randAd(), 1'b0, 1'b0, keepVma, 1'b0, r[4:0], 1'b1);
    loadVma(randAd(), 1'b0, 1'b1, fromPc, 1'b0, r[4:0], 1'b0);
  endtask

  task automatic countTest();
    int s;
    loadVma({12'd0, 1'b0, 5'd3, 18'h3ffff}, 1'b1, 1'b1, fromAd, 1'b0, 5'd0, 1'b0);
    vmaCount = 1'b1;
    tick();
    vmaCount = 1'b0;
    vmaModel = {1'b0, 5'd4, 18'd0};
    checkEq(vma, vmaModel, "vma after count carry");
    // Load must win over a simultaneous count
    vmaCount = 1'b1;
    loadVma(randAd(), 1'b1, 1'b1, fromAd, 1'b0, 5'd0, 1'b0);
    vmaCount = 1'b0;
    loadPrevSection();
    for (s = 0; s < 8; s++) begin
      loadVma(randAd(), 1'b1, s[2], sectionSrc_e'(s[1:0]), 1'b0, 5'd0, 1'b0);
    end
  endtask

  task automatic heldTest();
    loadHeld = 1'b1;
    tick();
    loadHeld = 1'b0;
    heldModel = vmaModel;
    loadVma({12'd0, heldModel ^ 24'h0a5a5a}, 1'b1, 1'b1, fromAd, 1'b0, 5'd0, 1'b0);
    selHeld = 1'b1;
    tick();
    checkEq(heldOrPc, heldModel, "heldOrPc selecting held");
    selHeld = 1'b0;
    tick();
    checkEq(heldOrPc, pcModel, "heldOrPc selecting pc");
  endtask

  task automatic matchTest();
    logic [`EBUS_WIDTH-1:0] adVal;
    int a;
    int c;
    adVal = randAd();
    ad = adVal;
    dataoApr = 1'b1;
    tick();
    dataoApr = 1'b0;
    adrBrkModel = {1'b0, adVal[22:0]};
    loadVma(adVal, 1'b1, 1'b1, fromAd, 1'b0, 5'd0, 1'b0);
    checkEq(match, 36'd1, "match on equal address");
    loadVma(adVal ^ 36'h800000, 1'b1, 1'b1, fromAd, 1'b0, 5'd0, 1'b0);
    checkEq(match, 36'd1, "match ignoring misc bit");
    loadVma(adVal ^ 36'h000100, 1'b1, 1'b1, fromAd, 1'b0, 5'd0, 1'b0);
    checkEq(match, 36'd0, "match on different address");
    // Misc, section, page and low nibble each zero or not
    for (a = 0; a < 16; a++) begin
      adVal = {12'd0, a[0], a[1] ? 5'd6 : 5'd0, 2'b00, a[2] ? 8'h40 : 8'h00,
               a[3] ? 8'hc3 : 8'h03};
      loadVma(adVal, 1'b1, 1'b1, fromAd, 1'b0, 5'd0, 1'b0);
      for (c = 0; c < 32; c++) begin
        {vmaExtended, vmaFetch, pageUebrRef, readOrWrite, adrErr} = c[4:0];
        tick();
        checkEq(acRef, acRefRule(vmaModel, c[4], c[3], c[2], c[1], c[0]), "acRef");
      end
    end
  endtask

  task automatic diagTest();
    int d;
    loadPrevSection();
    vmaExtended = 1'b1;
    vmaFetch = 1'b0;
    pageUebrRef = 1'b1;
    readOrWrite = 1'b1;
    adrErr = 1'b0;
    readVma = 1'b1;
    for (d = 0; d < 8; d++) begin
      diagSel = diagSel_e'(d[2:0]);
      tick();
      checkEq(ebusData, diagWordFor(diagSel, vmaModel, pcModel, heldModel, adrBrkModel,
              prevSecModel, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0), "ebusData");
      checkEq(ebusDriving, 36'd1, "ebusDriving while reading");
    end
    readVma = 1'b0;
    for (d = 0; d < 8; d++) begin
      diagSel = diagSel_e'(d[2:0]);
      tick();
      checkEq(ebusData, 36'd0, "ebusData while idle");
      checkEq(ebusDriving, 36'd0, "ebusDriving while idle");
    end
  endtask

  initial begin
    lcgState = 32'd11291;
    reset = 1'b1;
    ad = '0;
    magic = '0;
    magicEn = 1'b0;
    vmaLoad = 1'b0;
    vmaCount = 1'b0;
    vmaAdSel = 1'b0;
    vmaInc = 1'b0;
    sectionSrc = keepVma;
    sectionEn = 1'b0;
    loadPc = 1'b0;
    loadHeld = 1'b0;
    selHeld = 1'b0;
    loadPrevContext = 1'b0;
    dataoApr = 1'b0;
    vmaExtended = 1'b0;
    vmaFetch = 1'b0;
    pageUebrRef = 1'b0;
    readOrWrite = 1'b0;
    adrErr = 1'b0;
    readVma = 1'b0;
    diagSel = diagVma;
    vmaModel = '0;
    pcModel = '0;
    heldModel = '0;
    adrBrkModel = '0;
    prevSecModel = '0;
    // Sixteen rising edges with reset high
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    resetTest();
    loadTest();
    countTest();
    heldTest();
    matchTest();
    diagTest();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== vma/vmaContext.sv ====
`include "vma_params.svh"

module vmaContext (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`EBUS_WIDTH-1:0]  ad,
  input  logic                    loadPc,
  input  logic                    loadHeld,
  input  logic                    selHeld,
  input  logic                    loadPrevContext,
  input  logic                    dataoApr,
  output logic [`VMA_WIDTH-1:0]   heldOrPc,
  vmaBus.ctx                      bus
);
  import vmaPkg::*;

  vmaWord_u adWord;
  vmaWord_u pcReg;
  vmaWord_u heldReg;
  vmaWord_u adrBrkReg;
  logic [`VMA_SECTION_WIDTH-1:0] prevSecReg;

  assign adWord.flat = ad[`VMA_WIDTH-1:0];

  // PC and held copies of the VMA
  always_ff @(posedge clk) begin
    if (reset) begin
      pcReg   <= '0;
      heldReg <= '0;
    end else begin
      if (loadPc) begin
        pcReg <= bus.vma;
      end
      if (loadHeld) begin
        heldReg <= bus.vma;
      end
    end
  end

  // Previous context section and address break, both from the data path
  always_ff @(posedge clk) begin
    if (reset) begin
      prevSecReg <= '0;
      adrBrkReg  <= '0;
    end else begin
      if (loadPrevContext) begin
        prevSecReg <= adWord.f.section;
      end
      if (dataoApr) begin
        // No misc bit in the break address
        adrBrkReg.flat <= {1'b0, adWord.flat[`VMA_WIDTH-2:0]};
      end
    end
  end

  assign bus.pc      = pcReg;
  assign bus.held    = heldReg;
  assign bus.prevSec = prevSecReg;
  assign bus.adrBrk  = adrBrkReg;

  always_comb begin
    if (selHeld) begin
      heldOrPc = heldReg.flat;
    end else begin
      heldOrPc = pcReg.flat;
    end
  end

  adrBrkMiscZero: assert property (
    @(posedge clk) disable iff (reset) bus.adrBrk.f.misc == 1'b0
  );

endmodule

// ==== vma/vmaDecode.sv ====
`include "vma_params.svh"

module vmaDecode (
  input  logic                    vmaExtended,
  input  logic                    vmaFetch,
  input  logic                    pageUebrRef,
  input  logic                    readOrWrite,
  input  logic                    adrErr,
  input  logic                    readVma,
  input  vmaPkg::diagSel_e        diagSel,
  output logic                    acRef,
  output logic                    match,
  output logic [`EBUS_WIDTH-1:0]  ebusData,
  output logic                    ebusDriving,
  vmaBus.decode                   bus
);
  import vmaPkg::*;

  logic vmaSecZero;
  logic pcSecZero;
  logic prevSecZero;
  logic miscZero;
  logic pageZero;
  logic lowNibbleZero;
  logic isLocal;
  logic localAc;

  assign vmaSecZero  = bus.vma.f.section == '0;
  assign pcSecZero   = bus.pc.f.section == '0;
  assign prevSecZero = bus.prevSec == '0;

  assign miscZero = ~bus.vma.f.misc & (bus.vma.f.offset.hiPair == '0) & ~adrErr;

  assign pageZero = bus.vma.f.offset.page == '0;

  // Top nibble of the low byte, original bits 28..31
  assign lowNibbleZero = bus.vma.f.offset.low[7:4] == '0;

  // Unextended, fetch, or section zero all reference locally
  assign isLocal = ~vmaExtended | vmaFetch | vmaSecZero;

  assign acRef = pageZero &
                 (miscZero | lowNibbleZero) &
                 pageUebrRef &
                 readOrWrite &
                 isLocal;

  assign localAc = ~vmaSecZero & isLocal & miscZero & pageZero;

  // Break compare skips the misc bit
  assign match = bus.vma.flat[`VMA_WIDTH-2:0] == bus.adrBrk.flat[`VMA_WIDTH-2:0];

  always_comb begin
    ebusData = '0;
    if (readVma) begin
      case (diagSel)
        diagVma:     ebusData[`VMA_WIDTH-1:0] = bus.vma.flat;
        diagPc:      ebusData[`VMA_WIDTH-1:0] = bus.pc.flat;
        diagHeld:    ebusData[`VMA_WIDTH-1:0] = bus.held.flat;
        diagAdrBrk:  ebusData[`VMA_WIDTH-1:0] = bus.adrBrk.flat;
        diagPrevSec: ebusData[`VMA_SECTION_WIDTH-1:0] = bus.prevSec;
        diagFlags: begin
          ebusData[6:0] = {prevSecZero, pcSecZero, vmaSecZero, miscZero,
                           match, localAc, acRef};
        end
        default:     ebusData = '0;
      endcase
    end
  end

  assign ebusDriving = readVma;

  // Bus stays quiet whenever another board may own it
  always_comb begin
    ebusIdleZero: assert (ebusDriving || (ebusData == '0));
  end

endmodule

// ==== vma/vmaSource.sv ====
`include "vma_params.svh"

module vmaSource (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [`EBUS_WIDTH-1:0]        ad,
  input  logic [`VMA_MAGIC_WIDTH-1:0]   magic,
  input  logic                          magicEn,
  input  logic                          vmaAdSel,
  input  logic                          vmaInc,
  input  vmaPkg::sectionSrc_e           sectionSrc,
  input  logic                          sectionEn,
  input  logic                          vmaLoad,
  input  logic                          vmaCount,
  vmaBus.source                         bus
);
  import vmaPkg::*;

  vmaWord_u adWord;
  vmaWord_u vmaReg;
  vmaWord_u nextVma;

  logic [`VMA_OFFSET_WIDTH-1:0]  addend;
  logic [`VMA_OFFSET_WIDTH-1:0]  adderSum;
  logic [`VMA_SECTION_WIDTH-1:0] sectionMux;

  // Only the low address bits of the data path matter here
  assign adWord.flat = ad[`VMA_WIDTH-1:0];

  // PC plus magic, or PC plus the increment carry-in
  always_comb begin
    if (magicEn) begin
      addend = {{(`VMA_OFFSET_WIDTH-`VMA_MAGIC_WIDTH){1'b0}}, magic};
    end else begin
      addend = {{(`VMA_OFFSET_WIDTH-1){1'b0}}, vmaInc};
    end
    adderSum = bus.pc.f.offset + addend;
  end

  always_comb begin
    sectionMux = vmaReg.f.section;
    if (sectionEn) begin
      case (sectionSrc)
        keepVma:     sectionMux = vmaReg.f.section;
        fromPc:      sectionMux = bus.pc.f.section;
        fromPrevSec: sectionMux = bus.prevSec;
        fromAd:      sectionMux = adWord.f.section;
        default:     sectionMux = vmaReg.f.section;
      endcase
    end
  end

  always_comb begin
    nextVma.f.misc    = adWord.f.misc;
    nextVma.f.section = sectionMux;
    if (vmaAdSel) begin
      nextVma.f.offset = adWord.f.offset;
    end else begin
      nextVma.f.offset = adderSum;
    end
  end

  // Load wins over count
  always_ff @(posedge clk) begin
    if (reset) begin
      vmaReg <= '0;
    end else if (vmaLoad) begin
      vmaReg <= nextVma;
    end else if (vmaCount) begin
      // Flat count so the offset carries into the section
      vmaReg.flat <= vmaReg.flat + 1'b1;
    end
  end

  assign bus.vma = vmaReg;

  vmaZeroAfterReset: assert property (
    @(posedge clk) reset |=> (bus.vma.flat == '0)
  );

endmodule
